//--- compile.f
hw/pep_mmacc_pkg.sv
hw/pep_mmacc_gram_if.sv
hw/pep_mmacc_decode.sv
hw/pep_mmacc_gram_core.sv
hw/pep_mmacc_glwe_ram.sv
hw/pep_mmacc_acc_update.sv
hw/pep_mmacc_result.sv
hw/pep_mmacc_top.sv
verification/pep_mmacc_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module pep_mmacc_tb -f compile.f -o pep_mmacc_sim
out=$(./obj_dir/pep_mmacc_sim)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
else
  exit 1
fi

//--- verification/pep_mmacc_tb.sv
// Directed testbench for the GLWE accumulation memory with reference model, LFSR and timeout
module pep_mmacc_tb
  import pep_mmacc_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int RSP_LAT      = 5;
  localparam int RSP_WAIT     = 10;
  localparam int SXT_PER_CORE = 8;
  localparam int ACC_NB       = 8;
  localparam int CONFLICT_NB  = 6;
  localparam int CONFLICT_LEN = 1 + 5 + 8 + RSP_LAT + 1;
  localparam int MAX_CYCLES   = 2 * RESET_CYCLES + CORE_NB * GLWE_RAM_DEPTH
                              + (SXT_PER_CORE * CORE_NB + CORE_NB + ACC_NB + 1) * (RSP_LAT + 1)
                              + 2 * ACC_NB + 20 + CONFLICT_NB * CONFLICT_LEN + 100;

  logic      clk = 1'b0;
  logic      s_rst_n;
  logic      cmd_vld;
  cmd_op_e   cmd_op;
  core_idx_t cmd_core;
  gram_add_t cmd_add;
  gram_add_t cmd_add_b;
  op_data_t  cmd_data;
  logic      rsp_vld;
  op_data_t  rsp_data;
  op_data_t  rsp_data_b;
  logic      error;

  op_data_t    mem_model [CORE_NB][GLWE_RAM_DEPTH];
  logic [31:0] lfsr_state = 32'he5ce_65fc;
  int          err_cnt    = 0;
  int          pass_cnt   = 0;
  int          fail_cnt   = 0;
  int          cycle_cnt  = 0;

  pep_mmacc_top pep_mmacc_top_i (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_op     (cmd_op),
    .cmd_core   (cmd_core),
    .cmd_add    (cmd_add),
    .cmd_add_b  (cmd_add_b),
    .cmd_data   (cmd_data),
    .rsp_vld    (rsp_vld),
    .rsp_data   (rsp_data),
    .rsp_data_b (rsp_data_b),
    .error      (error)
  );

  always #20 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles before all tests ended", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Random numbers
  // ------------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // ------------------------------------------------------------
  // Compare and report
  // ------------------------------------------------------------
  task automatic check_data(input string name, input op_data_t exp, input op_data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_error(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%s: pass", name);
    end else begin
      fail_cnt++;
      $display("%s: FAIL with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // ------------------------------------------------------------
  // Command driving
  // ------------------------------------------------------------
  task automatic send_cmd(input cmd_op_e op, input core_idx_t core, input gram_add_t add,
                          input gram_add_t add_b, input op_data_t data);
    @(posedge clk);
    cmd_vld   <= 1'b1;
    cmd_op    <= op;
    cmd_core  <= core;
    cmd_add   <= add;
    cmd_add_b <= add_b;
    cmd_data  <= data;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
  endtask

  // Read, wait for the response and compare with the model
  task automatic read_check(input cmd_op_e op, input core_idx_t core,
                            input gram_add_t add, input gram_add_t add_b);
    int   wait_cnt;
    logic seen;
    wait_cnt = 0;
    seen     = 1'b0;
    send_cmd(op, core, add, add_b, '0);
    while (!seen && wait_cnt < RSP_WAIT) begin
      @(posedge clk);
      cmd_vld <= 1'b0;
      @(negedge clk);
      wait_cnt++;
      check_error("error", 1'b0, error);
      seen = rsp_vld;
    end
    if (!seen) begin
      $display("No response within %0d cycles of a read to core %0d", RSP_WAIT, core);
      err_cnt++;
    end else if (wait_cnt != RSP_LAT) begin
      $display("Response came %0d cycles after the read, expected %0d", wait_cnt, RSP_LAT);
      err_cnt++;
    end else begin
      check_data("rsp_data", mem_model[core][add], rsp_data);
      if (op == CMD_FEED_RD) begin
        check_data("rsp_data_b", mem_model[core][add_b], rsp_data_b);
      end
    end
  endtask

  // Accumulate, then a read gap cycles later; error expected 3 cycles after the read
  task automatic acc_then_read(input core_idx_t acc_core, input core_idx_t rd_core,
                               input int gap, input cmd_op_e rd_op, input logic exp_err);
    gram_add_t add;
    gram_add_t add_b;
    op_data_t  operand;
    add     = gram_add_t'(rand_bits(GRAM_ADD_W));
    add_b   = gram_add_t'(add + 1);
    operand = rand_bits(OP_W);
    send_cmd(CMD_ACC, acc_core, add, add, operand);
    mem_model[acc_core][add] = mem_model[acc_core][add] + operand;
    idle(gap - 1);
    send_cmd(rd_op, rd_core, add, add_b, '0);
    for (int i = 1; i <= 8; i++) begin
      @(posedge clk);
      cmd_vld <= 1'b0;
      @(negedge clk);
      check_error("error", exp_err && (i == 3), error);
      if (i == RSP_LAT && !rsp_vld) begin
        $display("No response %0d cycles after a read to core %0d", RSP_LAT, rd_core);
        err_cnt++;
      end else if (i == RSP_LAT && !exp_err) begin
        check_data("rsp_data", mem_model[rd_core][add], rsp_data);
        if (rd_op == CMD_FEED_RD) begin
          check_data("rsp_data_b", mem_model[rd_core][add_b], rsp_data_b);
        end
      end
    end
    // Write-back lands even when the read collided
    read_check(CMD_SXT_RD, acc_core, add, add);
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic reset_idle();
    int errs;
    errs = err_cnt;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_error("rsp_vld", 1'b0, rsp_vld);
      check_error("error", 1'b0, error);
    end
    @(posedge clk);
    s_rst_n <= 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_error("rsp_vld", 1'b0, rsp_vld);
      check_error("error", 1'b0, error);
    end
    report_test("reset", errs);
  endtask

  task automatic load_and_sxt_read();
    int       errs;
    op_data_t d;
    errs = err_cnt;
    for (int c = 0; c < CORE_NB; c++) begin
      for (int a = 0; a < GLWE_RAM_DEPTH; a++) begin
        d = rand_bits(OP_W);
        mem_model[c][a] = d;
        send_cmd(CMD_LOAD, core_idx_t'(c), gram_add_t'(a), gram_add_t'(a), d);
      end
    end
    idle(1);
    for (int c = 0; c < CORE_NB; c++) begin
      repeat (SXT_PER_CORE) begin
        read_check(CMD_SXT_RD, core_idx_t'(c), gram_add_t'(rand_bits(GRAM_ADD_W)), '0);
      end
    end
    report_test("load and sxt read", errs);
  endtask

  task automatic feed_read();
    int        errs;
    gram_add_t add;
    errs = err_cnt;
    for (int c = 0; c < CORE_NB; c++) begin
      add = gram_add_t'(rand_bits(GRAM_ADD_W));
      read_check(CMD_FEED_RD, core_idx_t'(c), add, gram_add_t'(add + 1 + rand_bits(5)));
    end
    report_test("feed read", errs);
  endtask

  task automatic accumulate();
    int        errs;
    gram_add_t base;
    gram_add_t add;
    core_idx_t core;
    op_data_t  operand;
    errs = err_cnt;
    base = gram_add_t'(rand_bits(GRAM_ADD_W));
    // Back to back, several in flight
    for (int i = 0; i < ACC_NB; i++) begin
      operand = rand_bits(OP_W);
      add     = gram_add_t'(base + i);
      mem_model[i % CORE_NB][add] = mem_model[i % CORE_NB][add] + operand;
      send_cmd(CMD_ACC, core_idx_t'(i % CORE_NB), add, add, operand);
    end
    idle(5);
    for (int i = 0; i < ACC_NB; i++) begin
      read_check(CMD_SXT_RD, core_idx_t'(i % CORE_NB), gram_add_t'(base + i), '0);
    end
    // Same address twice, 5 cycles apart
    add  = gram_add_t'(rand_bits(GRAM_ADD_W));
    core = core_idx_t'(rand_bits(CORE_IDX_W));
    repeat (2) begin
      operand = rand_bits(OP_W);
      mem_model[core][add] = mem_model[core][add] + operand;
      send_cmd(CMD_ACC, core, add, add, operand);
      idle(4);
    end
    idle(1);
    read_check(CMD_SXT_RD, core, add, add);
    report_test("accumulate", errs);
  endtask

  task automatic access_conflict();
    int        errs;
    core_idx_t c;
    errs = err_cnt;
    c    = core_idx_t'(rand_bits(CORE_IDX_W));
    acc_then_read(c, c, 4, CMD_SXT_RD, 1'b1);
    acc_then_read(c, c, 4, CMD_FEED_RD, 1'b1);
    acc_then_read(c, core_idx_t'(c + 1), 4, CMD_SXT_RD, 1'b0);
    acc_then_read(c, core_idx_t'(c + 1), 4, CMD_FEED_RD, 1'b0);
    acc_then_read(c, c, 5, CMD_SXT_RD, 1'b0);
    acc_then_read(c, c, 5, CMD_FEED_RD, 1'b0);
    report_test("access conflict", errs);
  endtask

  initial begin
    s_rst_n   = 1'b0;
    cmd_vld   = 1'b0;
    cmd_op    = CMD_LOAD;
    cmd_core  = '0;
    cmd_add   = '0;
    cmd_add_b = '0;
    cmd_data  = '0;
    reset_idle();
    load_and_sxt_read();
    feed_read();
    accumulate();
    access_conflict();
    $display("Tests passed %0d, tests failed %0d, failed checks %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hw/pep_mmacc_top.sv
// Top level joining decode, accumulate update, GLWE RAM array and response stage
module pep_mmacc_top
  import pep_mmacc_pkg::*;
(
  input  logic      clk,
  input  logic      s_rst_n,

  // Command, one strobe per cycle at most
  input  logic      cmd_vld,
  input  cmd_op_e   cmd_op,
  input  core_idx_t cmd_core,
  input  gram_add_t cmd_add,
  input  gram_add_t cmd_add_b,
  input  op_data_t  cmd_data,

  // Read response
  output logic      rsp_vld,
  output op_data_t  rsp_data,
  output op_data_t  rsp_data_b,

  output logic      error
);

  logic     acc_op_vld;
  op_data_t acc_op;

  gram_access_if gram ();

  pep_mmacc_decode pep_mmacc_decode_i (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_op     (cmd_op),
    .cmd_core   (cmd_core),
    .cmd_add    (cmd_add),
    .cmd_add_b  (cmd_add_b),
    .cmd_data   (cmd_data),
    .gram       (gram.decode),
    .acc_op_vld (acc_op_vld),
    .acc_op     (acc_op)
  );

  pep_mmacc_acc_update pep_mmacc_acc_update_i (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .acc_op_vld (acc_op_vld),
    .acc_op     (acc_op),
    .gram       (gram.acc)
  );

  pep_mmacc_glwe_ram pep_mmacc_glwe_ram_i (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .gram    (gram.ram),
    .error   (error)
  );

  pep_mmacc_result pep_mmacc_result_i (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .gram       (gram.result),
    .rsp_vld    (rsp_vld),
    .rsp_data   (rsp_data),
    .rsp_data_b (rsp_data_b)
  );

endmodule

//--- hw/pep_mmacc_result.sv
// Response selection over cores for sample extract and feed reads, registered output
module pep_mmacc_result
  import pep_mmacc_pkg::*;
(
  input  logic          clk,
  input  logic          s_rst_n,
  gram_access_if.result gram,
  output logic          rsp_vld,
  output op_data_t      rsp_data,
  output op_data_t      rsp_data_b
);

  logic     sel_vld;
  op_data_t sel_data;
  op_data_t sel_data_b;

  // At most one core returns data in a given cycle
  always_comb begin
    sel_vld    = 1'b0;
    sel_data   = '0;
    sel_data_b = '0;
    for (int c = 0; c < CORE_NB; c++) begin
      if (gram.sxt_rd_avail[c]) begin
        sel_vld  = 1'b1;
        sel_data = gram.sxt_rd_data[c];
      end
      if (|gram.feed_rd_avail[c]) begin
        sel_vld    = 1'b1;
        // Port a word first, port b word second
        sel_data   = gram.feed_rd_data[c][0];
        sel_data_b = gram.feed_rd_data[c][1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= sel_vld;
    end
  end

  always_ff @(posedge clk) begin
    rsp_data   <= sel_data;
    rsp_data_b <= sel_data_b;
  end

endmodule

//--- hw/pep_mmacc_acc_update.sv
// Accumulate operand delay line and modulo 2^32 adder issuing RAM write-backs
module pep_mmacc_acc_update
  import pep_mmacc_pkg::*;
(
  input  logic       clk,
  input  logic       s_rst_n,
  input  logic       acc_op_vld,
  input  op_data_t   acc_op,
  gram_access_if.acc gram
);

  // Stage 0 is the decode output, the rest are registers
  logic      in_vld;
  core_idx_t in_core;
  gram_add_t in_add;
  op_data_t  in_op;

  logic      dly_vld  [1:ACC_RD_LATENCY];
  core_idx_t dly_core [1:ACC_RD_LATENCY];
  gram_add_t dly_add  [1:ACC_RD_LATENCY];
  op_data_t  dly_op   [1:ACC_RD_LATENCY];

  // Encode the one-hot read enable into a core number and its address
  always_comb begin
    in_vld  = acc_op_vld;
    in_op   = acc_op;
    in_core = '0;
    in_add  = '0;
    for (int c = 0; c < CORE_NB; c++) begin
      if (gram.acc_rd_en[c]) begin
        in_core = core_idx_t'(c);
        in_add  = gram.acc_rd_add[c];
      end
    end
  end

  // ------------------------------------------------------------
  // Delay line
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      for (int i = 1; i <= ACC_RD_LATENCY; i++) begin
        dly_vld[i] <= 1'b0;
      end
    end else begin
      dly_vld[1] <= in_vld;
      for (int i = 2; i <= ACC_RD_LATENCY; i++) begin
        dly_vld[i] <= dly_vld[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    dly_core[1] <= in_core;
    dly_add[1]  <= in_add;
    dly_op[1]   <= in_op;
    for (int i = 2; i <= ACC_RD_LATENCY; i++) begin
      dly_core[i] <= dly_core[i-1];
      dly_add[i]  <= dly_add[i-1];
      dly_op[i]   <= dly_op[i-1];
    end
  end

  // ------------------------------------------------------------
  // Add and write back
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      gram.acc_wr_en <= '0;
    end else begin
      for (int c = 0; c < CORE_NB; c++) begin
        gram.acc_wr_en[c] <= gram.acc_rd_avail[c] && dly_vld[ACC_RD_LATENCY]
                             && (dly_core[ACC_RD_LATENCY] == core_idx_t'(c));
      end
    end
  end

  // Wraps naturally at OP_W bits
  always_ff @(posedge clk) begin
    for (int c = 0; c < CORE_NB; c++) begin
      gram.acc_wr_add[c]  <= dly_add[ACC_RD_LATENCY];
      gram.acc_wr_data[c] <= gram.acc_rd_data[c] + dly_op[ACC_RD_LATENCY];
    end
  end

endmodule

//--- hw/pep_mmacc_glwe_ram.sv
// Array of GLWE RAM cores over groups and lanes with a registered access conflict flag
module pep_mmacc_glwe_ram
  import pep_mmacc_pkg::*;
(
  input  logic       clk,
  input  logic       s_rst_n,
  gram_access_if.ram gram,
  output logic       error
);

  logic [CORE_NB-1:0] access_conflict;

  // ------------------------------------------------------------
  // Core array
  // ------------------------------------------------------------
  for (genvar gen_g = 0; gen_g < GRAM_NB; gen_g++) begin : gen_grp
    for (genvar gen_p = 0; gen_p < PSI; gen_p++) begin : gen_lane
      // Flat core number into the interface arrays
      localparam int C = gen_g * PSI + gen_p;

      pep_mmacc_gram_core pep_mmacc_gram_core_i (
        .clk           (clk),
        .s_rst_n       (s_rst_n),

        .ext_wr_en     (gram.ext_wr_en[C]),
        .ext_wr_add    (gram.ext_wr_add[C]),
        .ext_wr_data   (gram.ext_wr_data[C]),

        .sxt_rd_en     (gram.sxt_rd_en[C]),
        .sxt_rd_add    (gram.sxt_rd_add[C]),
        .sxt_rd_data   (gram.sxt_rd_data[C]),
        .sxt_rd_avail  (gram.sxt_rd_avail[C]),

        .feed_rd_en    (gram.feed_rd_en[C]),
        .feed_rd_add   (gram.feed_rd_add[C]),
        .feed_rd_data  (gram.feed_rd_data[C]),
        .feed_rd_avail (gram.feed_rd_avail[C]),

        .acc_rd_en     (gram.acc_rd_en[C]),
        .acc_rd_add    (gram.acc_rd_add[C]),
        .acc_rd_data   (gram.acc_rd_data[C]),
        .acc_rd_avail  (gram.acc_rd_avail[C]),

        .acc_wr_en     (gram.acc_wr_en[C]),
        .acc_wr_add    (gram.acc_wr_add[C]),
        .acc_wr_data   (gram.acc_wr_data[C]),

        .error         (access_conflict[C])
      );
    end
  end

  // ------------------------------------------------------------
  // Error flag
  // ------------------------------------------------------------
  // One cycle behind the colliding access
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      error <= 1'b0;
    end else begin
      error <= |access_conflict;
    end
  end

endmodule

//--- hw/pep_mmacc_gram_core.sv
// Two-port GLWE RAM core with input pipe, port muxing, conflict check and output pipe
module pep_mmacc_gram_core
  import pep_mmacc_pkg::*;
(
  input  logic            clk,
  input  logic            s_rst_n,

  input  logic            ext_wr_en,
  input  gram_add_t       ext_wr_add,
  input  op_data_t        ext_wr_data,

  input  logic            sxt_rd_en,
  input  gram_add_t       sxt_rd_add,
  output op_data_t        sxt_rd_data,
  output logic            sxt_rd_avail,

  input  logic [1:0]      feed_rd_en,
  input  gram_add_t [1:0] feed_rd_add,
  output op_data_t [1:0]  feed_rd_data,
  output logic [1:0]      feed_rd_avail,

  input  logic            acc_rd_en,
  input  gram_add_t       acc_rd_add,
  output op_data_t        acc_rd_data,
  output logic            acc_rd_avail,

  input  logic            acc_wr_en,
  input  gram_add_t       acc_wr_add,
  input  op_data_t        acc_wr_data,

  output logic            error
);

  logic            ext_wr_en_q, sxt_rd_en_q, acc_rd_en_q, acc_wr_en_q;
  logic [1:0]      feed_rd_en_q;
  gram_add_t       ext_wr_add_q, sxt_rd_add_q, acc_rd_add_q, acc_wr_add_q;
  gram_add_t [1:0] feed_rd_add_q;
  op_data_t        ext_wr_data_q, acc_wr_data_q;

  gram_add_t       a_add, b_add;
  logic            a_conflict, b_conflict;
  op_data_t        a_rd_data, b_rd_data;
  logic            sxt_rd_d, feed0_rd_d, feed1_rd_d, acc_rd_d;

  op_data_t        mem [GLWE_RAM_DEPTH];

  // ------------------------------------------------------------
  // Input pipe
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ext_wr_en_q  <= 1'b0;
      sxt_rd_en_q  <= 1'b0;
      feed_rd_en_q <= 2'b00;
      acc_rd_en_q  <= 1'b0;
      acc_wr_en_q  <= 1'b0;
    end else begin
      ext_wr_en_q  <= ext_wr_en;
      sxt_rd_en_q  <= sxt_rd_en;
      feed_rd_en_q <= feed_rd_en;
      acc_rd_en_q  <= acc_rd_en;
      acc_wr_en_q  <= acc_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    ext_wr_add_q  <= ext_wr_add;
    ext_wr_data_q <= ext_wr_data;
    sxt_rd_add_q  <= sxt_rd_add;
    feed_rd_add_q <= feed_rd_add;
    acc_rd_add_q  <= acc_rd_add;
    acc_wr_add_q  <= acc_wr_add;
    acc_wr_data_q <= acc_wr_data;
  end

  // ------------------------------------------------------------
  // Port muxing and conflict check
  // ------------------------------------------------------------
  // Writes win on both ports
  assign a_add = ext_wr_en_q     ? ext_wr_add_q :
                 feed_rd_en_q[0] ? feed_rd_add_q[0] : acc_rd_add_q;
  assign b_add = acc_wr_en_q     ? acc_wr_add_q :
                 sxt_rd_en_q     ? sxt_rd_add_q : feed_rd_add_q[1];

  // Two or more requests on the same port
  assign a_conflict = (ext_wr_en_q & feed_rd_en_q[0]) | (ext_wr_en_q & acc_rd_en_q)
                    | (feed_rd_en_q[0] & acc_rd_en_q);
  assign b_conflict = (acc_wr_en_q & sxt_rd_en_q) | (acc_wr_en_q & feed_rd_en_q[1])
                    | (sxt_rd_en_q & feed_rd_en_q[1]);
  assign error      = a_conflict | b_conflict;

  // RAM array, one read-write access per port
  always_ff @(posedge clk) begin
    if (ext_wr_en_q) begin
      mem[a_add] <= ext_wr_data_q;
    end
    if (acc_wr_en_q) begin
      mem[b_add] <= acc_wr_data_q;
    end
    a_rd_data <= mem[a_add];
    b_rd_data <= mem[b_add];
  end

  // Track which actor owns the data coming out of the RAM
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sxt_rd_d   <= 1'b0;
      feed0_rd_d <= 1'b0;
      feed1_rd_d <= 1'b0;
      acc_rd_d   <= 1'b0;
    end else begin
      sxt_rd_d   <= sxt_rd_en_q;
      feed0_rd_d <= feed_rd_en_q[0];
      feed1_rd_d <= feed_rd_en_q[1];
      acc_rd_d   <= acc_rd_en_q;
    end
  end

  // ------------------------------------------------------------
  // Output pipe
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sxt_rd_avail  <= 1'b0;
      feed_rd_avail <= 2'b00;
      acc_rd_avail  <= 1'b0;
    end else begin
      sxt_rd_avail  <= sxt_rd_d;
      feed_rd_avail <= {feed1_rd_d, feed0_rd_d};
      acc_rd_avail  <= acc_rd_d;
    end
  end

  always_ff @(posedge clk) begin
    sxt_rd_data     <= b_rd_data;
    feed_rd_data[0] <= a_rd_data;
    feed_rd_data[1] <= b_rd_data;
    acc_rd_data     <= a_rd_data;
  end

endmodule

//--- hw/pep_mmacc_decode.sv
// Command decoder producing registered per-core RAM requests and the accumulate operand
module pep_mmacc_decode
  import pep_mmacc_pkg::*;
(
  input  logic          clk,
  input  logic          s_rst_n,
  input  logic          cmd_vld,
  input  cmd_op_e       cmd_op,
  input  core_idx_t     cmd_core,
  input  gram_add_t     cmd_add,
  input  gram_add_t     cmd_add_b,
  input  op_data_t      cmd_data,
  gram_access_if.decode gram,
  output logic          acc_op_vld,
  output op_data_t      acc_op
);

  logic [CORE_NB-1:0] core_sel;
  logic [CORE_NB-1:0] load_sel;
  logic [CORE_NB-1:0] acc_sel;
  logic [CORE_NB-1:0] sxt_sel;
  logic [CORE_NB-1:0] feed_sel;

  // One-hot core select, empty when no command
  assign core_sel = cmd_vld ? (CORE_NB'(1) << cmd_core) : '0;

  assign load_sel = (cmd_op == CMD_LOAD)    ? core_sel : '0;
  assign acc_sel  = (cmd_op == CMD_ACC)     ? core_sel : '0;
  assign sxt_sel  = (cmd_op == CMD_SXT_RD)  ? core_sel : '0;
  assign feed_sel = (cmd_op == CMD_FEED_RD) ? core_sel : '0;

  // ------------------------------------------------------------
  // Request strobes
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      gram.ext_wr_en  <= '0;
      gram.sxt_rd_en  <= '0;
      gram.feed_rd_en <= '0;
      gram.acc_rd_en  <= '0;
      acc_op_vld      <= 1'b0;
    end else begin
      gram.ext_wr_en <= load_sel;
      gram.sxt_rd_en <= sxt_sel;
      // Feed reads hit both ports of the core at once
      for (int c = 0; c < CORE_NB; c++) begin
        gram.feed_rd_en[c] <= {2{feed_sel[c]}};
      end
      gram.acc_rd_en <= acc_sel;
      acc_op_vld     <= cmd_vld && (cmd_op == CMD_ACC);
    end
  end

  // ------------------------------------------------------------
  // Addresses and data
  // ------------------------------------------------------------
  // Same payload to every core, the strobes pick the target
  always_ff @(posedge clk) begin
    for (int c = 0; c < CORE_NB; c++) begin
      gram.ext_wr_add[c]     <= cmd_add;
      gram.ext_wr_data[c]    <= cmd_data;
      gram.sxt_rd_add[c]     <= cmd_add;
      gram.feed_rd_add[c][0] <= cmd_add;
      gram.feed_rd_add[c][1] <= cmd_add_b;
      gram.acc_rd_add[c]     <= cmd_add;
    end
    acc_op <= cmd_data;
  end

endmodule

//--- hw/pep_mmacc_gram_if.sv
// Per-core GLWE RAM access interface with decode, acc, ram and result modports
interface gram_access_if
  import pep_mmacc_pkg::*;
();

  // External write, port a
  logic     [CORE_NB-1:0]      ext_wr_en;
  gram_add_t [CORE_NB-1:0]     ext_wr_add;
  op_data_t [CORE_NB-1:0]      ext_wr_data;

  // Sample extract read, port b
  logic     [CORE_NB-1:0]      sxt_rd_en;
  gram_add_t [CORE_NB-1:0]     sxt_rd_add;
  op_data_t [CORE_NB-1:0]      sxt_rd_data;
  logic     [CORE_NB-1:0]      sxt_rd_avail;

  // Feed read, index 0 on port a and index 1 on port b
  logic     [CORE_NB-1:0][1:0] feed_rd_en;
  gram_add_t [CORE_NB-1:0][1:0] feed_rd_add;
  op_data_t [CORE_NB-1:0][1:0] feed_rd_data;
  logic     [CORE_NB-1:0][1:0] feed_rd_avail;

  // Accumulate read on port a, write-back on port b
  logic     [CORE_NB-1:0]      acc_rd_en;
  gram_add_t [CORE_NB-1:0]     acc_rd_add;
  op_data_t [CORE_NB-1:0]      acc_rd_data;
  logic     [CORE_NB-1:0]      acc_rd_avail;
  logic     [CORE_NB-1:0]      acc_wr_en;
  gram_add_t [CORE_NB-1:0]     acc_wr_add;
  op_data_t [CORE_NB-1:0]      acc_wr_data;

  modport decode (
    output ext_wr_en, ext_wr_add, ext_wr_data,
    output sxt_rd_en, sxt_rd_add,
    output feed_rd_en, feed_rd_add,
    output acc_rd_en, acc_rd_add
  );

  modport acc (
    input  acc_rd_en, acc_rd_add, acc_rd_data, acc_rd_avail,
    output acc_wr_en, acc_wr_add, acc_wr_data
  );

  modport ram (
    input  ext_wr_en, ext_wr_add, ext_wr_data,
    input  sxt_rd_en, sxt_rd_add, feed_rd_en, feed_rd_add,
    input  acc_rd_en, acc_rd_add, acc_wr_en, acc_wr_add, acc_wr_data,
    output sxt_rd_data, sxt_rd_avail, feed_rd_data, feed_rd_avail,
    output acc_rd_data, acc_rd_avail
  );

  modport result (
    input  sxt_rd_data, sxt_rd_avail, feed_rd_data, feed_rd_avail
  );

endinterface

//--- hw/pep_mmacc_pkg.sv
// Package with widths, RAM geometry, pipeline latencies, data types and command encoding
package pep_mmacc_pkg;

  // ------------------------------------------------------------
  // Data and geometry
  // ------------------------------------------------------------
  localparam int OP_W           = 32;
  localparam int GRAM_NB        = 2;
  localparam int PSI            = 2;
  localparam int CORE_NB        = GRAM_NB * PSI;
  localparam int GLWE_RAM_DEPTH = 64;
  localparam int GRAM_ADD_W     = $clog2(GLWE_RAM_DEPTH);
  localparam int CORE_IDX_W     = $clog2(CORE_NB);

  // ------------------------------------------------------------
  // Core pipeline
  // ------------------------------------------------------------
  // Request register in front of the RAM
  localparam int IN_PIPE        = 1;
  // Synchronous read of the RAM itself
  localparam int RAM_LATENCY    = 1;
  // Data and avail register behind the RAM
  localparam int OUT_PIPE       = 1;
  // Decode output to acc read data available
  localparam int ACC_RD_LATENCY = IN_PIPE + RAM_LATENCY + OUT_PIPE;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  typedef logic [OP_W-1:0]       op_data_t;
  typedef logic [GRAM_ADD_W-1:0] gram_add_t;
  // Core c sits in group c / PSI, lane c % PSI
  typedef logic [CORE_IDX_W-1:0] core_idx_t;

  typedef enum logic [1:0] {
    CMD_LOAD,
    CMD_ACC,
    CMD_SXT_RD,
    CMD_FEED_RD
  } cmd_op_e;

endpackage
